//--- project.f
common/ex_pkg.sv
verilog/ex_pipe_reg.sv
verilog/ex_operand_sel.sv
alu/ex_alu.sv
verilog/ex_branch_unit.sv
verilog/ex_stage.sv
verif/tb_ex_stage.sv

//--- run.sh
#!/bin/sh
# Build the execute stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tb_ex_stage -o tb_ex_stage
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_ex_stage)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1

//--- verif/tb_ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ex_stage;
    import ex_pkg::*;

    localparam int CLK_PERIOD      = 10;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int WATCHDOG_NS     = NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD;

    logic    iw_clk = 1'b0;
    logic    iw_rst;
    ex_req_t req;
    logic    stall;
    logic    flush;
    ex_ctl_t ctl;
    ex_res_t res;

    // Reference model state
    flags_t  m_flags;
    imm_t    m_upper;
    ex_ctl_t exp_ctl;
    ex_res_t exp_res;

    logic [31:0] seed = 32'h23bd5523;
    int checks;
    int errors;
    int test_checks_start;
    int test_errors_start;
    int tests_done;

    ex_stage dut_i (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .req    (req),
        .stall  (stall),
        .flush  (flush),
        .ctl    (ctl),
        .res    (res)
    );

    always #(CLK_PERIOD / 2) iw_clk = ~iw_clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic data_t rand_data();
        return data_t'(next_rand());
    endfunction

    function automatic imm_t rand_imm();
        return imm_t'(next_rand());
    endfunction

    function automatic ex_req_t make_req(opc_t opc, cc_t cc, imm_t imm, data_t src, data_t tgt);
        ex_req_t r;
        r.pc        = addr_t'(next_rand());
        r.instr     = rand_data();
        r.opc       = opc;
        r.imm       = imm;
        r.cc        = cc;
        r.tgt_gp    = reg_idx_t'(next_rand());
        r.tgt_gp_we = next_rand() > 32'h7fffffff;
        r.src_val   = src;
        r.tgt_val   = tgt;
        return r;
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_outputs();
        check_field("ctl.pc", 32'(exp_ctl.pc), 32'(ctl.pc));
        check_field("ctl.instr", 32'(exp_ctl.instr), 32'(ctl.instr));
        check_field("ctl.opc", 32'(exp_ctl.opc), 32'(ctl.opc));
        check_field("ctl.tgt_gp", 32'(exp_ctl.tgt_gp), 32'(ctl.tgt_gp));
        check_field("ctl.tgt_gp_we", 32'(exp_ctl.tgt_gp_we), 32'(ctl.tgt_gp_we));
        check_field("res.addr", 32'(exp_res.addr), 32'(res.addr));
        check_field("res.result", 32'(exp_res.result), 32'(res.result));
        check_field("res.branch_taken", 32'(exp_res.branch_taken), 32'(res.branch_taken));
        check_field("res.branch_pc", 32'(exp_res.branch_pc), 32'(res.branch_pc));
        check_field("flags", 32'(m_flags), 32'(dut_i.br_i.flags));
    endtask

    // Result, address and flags of one instruction against the current model state
    task automatic predict_alu(input ex_req_t r, output data_t result, output addr_t addr,
                               output flags_t nf, output logic we);
        data_t           b;
        data_t           t;
        logic            zr;
        int              ti;
        int              bi;
        int              si;
        t = r.tgt_val;
        case (r.opc)
            OPC_MOVIU, OPC_ADDIU, OPC_SUBIU, OPC_ANDIU, OPC_ORIU, OPC_XORIU,
            OPC_SHLIU, OPC_SHRIU, OPC_CMPIU, OPC_STIU:
                b = {m_upper, r.imm};
            OPC_MOVIS, OPC_ADDIS, OPC_SUBIS, OPC_SHRIS, OPC_CMPIS, OPC_STIS:
                b = data_t'($signed(r.imm));
            default:
                b = r.src_val;
        endcase
        ti = int'($signed(t));
        bi = int'($signed(b));
        result = '0;
        addr   = '0;
        nf     = m_flags;
        we     = 1'b1;
        zr     = 1'b1;
        case (r.opc)
            OPC_MOVU, OPC_MOVIU, OPC_MOVIS: result = b;
            OPC_NOTU:                       result = ~t;
            OPC_ANDU, OPC_ANDIU:            result = t & b;
            OPC_ORU, OPC_ORIU:              result = t | b;
            OPC_XORU, OPC_XORIU:            result = t ^ b;
            OPC_ADDU, OPC_ADDIU: begin
                si     = int'(t) + int'(b);
                result = data_t'(si);
                nf.c   = si > 16777215; // Past the 24-bit unsigned range
            end
            OPC_SUBU, OPC_SUBIU: begin
                result = t - b;
                nf.c   = t < b; // Borrow
            end
            OPC_CMPU, OPC_CMPIU: begin
                zr   = 1'b0;
                nf.z = t == b;
                nf.c = t < b;
            end
            OPC_ADDS, OPC_ADDIS, OPC_SUBS, OPC_SUBIS, OPC_CMPS, OPC_CMPIS: begin
                if (r.opc == OPC_ADDS || r.opc == OPC_ADDIS) begin
                    si = ti + bi;
                end else begin
                    si = ti - bi;
                end
                nf.n = si[DATA_W-1];
                nf.v = (si > 8388607) || (si < -8388608); // Outside 24-bit signed range
                if (r.opc == OPC_CMPS || r.opc == OPC_CMPIS) begin
                    zr   = 1'b0;
                    nf.z = t == b;
                end else begin
                    result = data_t'(si);
                end
            end
            OPC_SHLU, OPC_SHLIU, OPC_SHRU, OPC_SHRIU, OPC_SHRS, OPC_SHRIS: begin
                nf.v = b > 24'd23;
                if (nf.v) begin
                    result = '0;
                end else if (r.opc == OPC_SHLU || r.opc == OPC_SHLIU) begin
                    result = t << b[4:0];
                end else if (r.opc == OPC_SHRU || r.opc == OPC_SHRIU) begin
                    result = t >> b[4:0];
                end else begin
                    result = data_t'($signed(t) >>> b[4:0]);
                end
                if (r.opc == OPC_SHRS || r.opc == OPC_SHRIS) begin
                    nf.n = result[DATA_W-1];
                end
            end
            OPC_LDU: begin
                addr = r.src_val;
                we   = 1'b0;
            end
            OPC_STU, OPC_STIU, OPC_STIS: begin
                addr   = t;
                result = b;
                we     = 1'b0;
            end
            OPC_LUI, OPC_JCCU, OPC_BCCS, OPC_JCCIU, OPC_BCCIS: we = 1'b0;
            default: begin
                zr = 1'b0;
                nf = '0;
            end
        endcase
        if (zr && we) begin
            nf.z = result == '0;
        end
    endtask

    function automatic logic cond_holds(cc_t cc, flags_t f);
        case (cc)
            CC_RA:   return 1'b1;
            CC_EQ:   return f.z;
            CC_NE:   return !f.z;
            CC_LT:   return f.n ^ f.v;
            CC_GE:   return !(f.n ^ f.v);
            CC_GT:   return !f.z && !(f.n ^ f.v);
            CC_LE:   return f.z || (f.n ^ f.v);
            CC_BT:   return f.c;
            CC_AE:   return !f.c;
            CC_AT:   return !(f.c || f.z);
            CC_BE:   return f.c || f.z;
            default: return 1'b0;
        endcase
    endfunction

    function automatic addr_t branch_target(ex_req_t r);
        case (r.opc)
            OPC_JCCU:  return r.pc + r.src_val;
            OPC_BCCS:  return addr_t'($signed(r.pc) + $signed(r.src_val));
            OPC_JCCIU: return {m_upper, r.imm};
            OPC_BCCIS: return r.pc + data_t'($signed(r.imm));
            default:   return '0;
        endcase
    endfunction

    // Entered and left 1 ns after a rising edge
    task automatic run_cycle(input ex_req_t r, input logic st, input logic fl);
        data_t  result;
        addr_t  addr;
        flags_t nf;
        logic   nf_we;
        logic   taken;
        addr_t  target;
        req   = r;
        stall = st;
        flush = fl;
        predict_alu(r, result, addr, nf, nf_we);
        taken  = (r.opc inside {OPC_JCCU, OPC_BCCS, OPC_JCCIU, OPC_BCCIS}) &&
                 cond_holds(r.cc, m_flags);
        target = taken ? branch_target(r) : '0;
        @(posedge iw_clk);
        #1;
        if (fl) begin
            exp_ctl = '0;
            exp_res = '0;
        end else if (!st) begin
            exp_ctl = '{pc: r.pc, instr: r.instr, opc: r.opc, tgt_gp: r.tgt_gp,
                        tgt_gp_we: r.tgt_gp_we};
            exp_res = '{addr: addr, result: result, branch_taken: taken, branch_pc: target};
            if (nf_we) begin
                m_flags = nf;
            end
            if (r.opc == OPC_LUI) begin
                m_upper = r.imm;
            end
        end
        check_outputs();
    endtask

    task automatic finish_test(input string name);
        tests_done++;
        $display("%s: %0d checks, %0d errors", name, checks - test_checks_start,
                 errors - test_errors_start);
        test_checks_start = checks;
        test_errors_start = errors;
    endtask

    task automatic test_reset();
        repeat (3) begin
            req = make_req(OPC_ADDU, CC_RA, rand_imm(), rand_data(), rand_data());
            @(posedge iw_clk);
            #1;
            check_outputs();
        end
        iw_rst = 1'b0;
        check_outputs();
        run_cycle('0, 1'b0, 1'b0); // All-zero request decodes as LUI 0
    endtask

    task automatic test_reg_ops();
        opc_t  ops[14];
        data_t src;
        data_t tgt;
        ops = '{OPC_MOVU, OPC_ADDU, OPC_SUBU, OPC_NOTU, OPC_ANDU, OPC_ORU, OPC_XORU,
                OPC_SHLU, OPC_SHRU, OPC_CMPU, OPC_ADDS, OPC_SUBS, OPC_SHRS, OPC_CMPS};
        foreach (ops[k]) begin
            for (int i = 0; i < 4; i++) begin
                tgt = rand_data();
                case (i)
                    0:       src = rand_data();
                    1:       src = rand_data() & 24'h00001f; // Around the 24 limit
                    2:       src = rand_data() & 24'h00000f;
                    default: src = tgt;
                endcase
                run_cycle(make_req(ops[k], CC_RA, rand_imm(), src, tgt), 1'b0, 1'b0);
            end
        end
    endtask

    task automatic test_imm();
        opc_t iu_ops[9];
        opc_t is_ops[5];
        imm_t imm;
        iu_ops = '{OPC_MOVIU, OPC_ADDIU, OPC_SUBIU, OPC_ANDIU, OPC_ORIU, OPC_XORIU,
                   OPC_SHLIU, OPC_SHRIU, OPC_CMPIU};
        is_ops = '{OPC_MOVIS, OPC_ADDIS, OPC_SUBIS, OPC_SHRIS, OPC_CMPIS};
        foreach (iu_ops[j]) begin
            for (int k = 0; k < 2; k++) begin
                imm = (k == 0) ? rand_imm() : 12'h000;
                run_cycle(make_req(OPC_LUI, CC_RA, imm, rand_data(), rand_data()), 1'b0, 1'b0);
                imm = (k == 0) ? rand_imm() : (rand_imm() & 12'h01f);
                run_cycle(make_req(iu_ops[j], CC_RA, imm, rand_data(), rand_data()),
                          1'b0, 1'b0);
            end
        end
        foreach (is_ops[j]) begin
            for (int k = 0; k < 3; k++) begin
                imm = (k < 2) ? (rand_imm() | 12'h800) : (rand_imm() & 12'h00f);
                run_cycle(make_req(is_ops[j], CC_RA, imm, rand_data(), rand_data()),
                          1'b0, 1'b0);
            end
        end
    endtask

    task automatic test_branch();
        opc_t  cmp_ops[4];
        opc_t  br_ops[4];
        imm_t  imm;
        data_t src;
        data_t tgt;
        cmp_ops = '{OPC_CMPU, OPC_CMPS, OPC_CMPIU, OPC_CMPIS};
        br_ops  = '{OPC_JCCU, OPC_BCCS, OPC_JCCIU, OPC_BCCIS};
        foreach (cmp_ops[a]) begin
            foreach (br_ops[b]) begin
                for (int c = 0; c < 11; c++) begin
                    imm = rand_imm();
                    src = rand_data();
                    tgt = rand_data();
                    if (c % 3 == 0) begin // Equal operands
                        case (cmp_ops[a])
                            OPC_CMPIU: tgt = {m_upper, imm};
                            OPC_CMPIS: tgt = {{12{imm[11]}}, imm};
                            default:   tgt = src;
                        endcase
                    end else if (c % 3 == 2) begin
                        tgt = tgt & 24'h0000ff;
                    end
                    run_cycle(make_req(cmp_ops[a], CC_RA, imm, src, tgt), 1'b0, 1'b0);
                    run_cycle(make_req(br_ops[b], cc_t'(c), rand_imm(), rand_data(),
                                       rand_data()), 1'b0, 1'b0);
                end
            end
        end
    endtask

    task automatic test_mem();
        opc_t ops[4];
        ops = '{OPC_LDU, OPC_STU, OPC_STIU, OPC_STIS};
        foreach (ops[k]) begin
            repeat (3) begin
                run_cycle(make_req(ops[k], CC_RA, rand_imm(), rand_data(), rand_data()),
                          1'b0, 1'b0);
            end
        end
    endtask

    task automatic test_stall_flush();
        run_cycle(make_req(OPC_CMPS, CC_RA, rand_imm(), rand_data(), rand_data()), 1'b0, 1'b0);
        repeat (4) begin
            run_cycle(make_req(OPC_ADDU, CC_RA, rand_imm(), rand_data(), rand_data()),
                      1'b1, 1'b0);
        end
        run_cycle(make_req(OPC_LUI, CC_RA, rand_imm(), rand_data(), rand_data()), 1'b1, 1'b0);
        // Target shows the upper immediate survived the stalled LUI
        run_cycle(make_req(OPC_JCCIU, CC_RA, rand_imm(), rand_data(), rand_data()), 1'b0, 1'b0);
        repeat (3) begin
            run_cycle(make_req(OPC_CMPU, CC_RA, rand_imm(), rand_data(), rand_data()),
                      1'b0, 1'b1);
        end
        run_cycle(make_req(OPC_SUBS, CC_RA, rand_imm(), rand_data(), rand_data()), 1'b1, 1'b1);
        for (int c = 0; c < 11; c++) begin
            run_cycle(make_req(OPC_BCCIS, cc_t'(c), rand_imm(), rand_data(), rand_data()),
                      1'b0, 1'b0);
        end
    endtask

    initial begin
        iw_rst            = 1'b1;
        stall             = 1'b0;
        flush             = 1'b0;
        req               = '0;
        m_flags           = '0;
        m_upper           = '0;
        exp_ctl           = '0;
        exp_res           = '0;
        checks            = 0;
        errors            = 0;
        test_checks_start = 0;
        test_errors_start = 0;
        tests_done        = 0;
        test_reset();
        finish_test("reset");
        test_reg_ops();
        finish_test("register ops");
        test_imm();
        finish_test("immediates");
        test_branch();
        finish_test("branches");
        test_mem();
        finish_test("memory");
        test_stall_flush();
        finish_test("stall and flush");
        $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/ex_stage.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage (
    input  wire              iw_clk,
    input  wire              iw_rst,
    input  wire ex_pkg::ex_req_t req,
    input  wire              stall,
    input  wire              flush,
    output ex_pkg::ex_ctl_t  ctl,
    output ex_pkg::ex_res_t  res
);
    import ex_pkg::*;

    logic     advance;
    data_t    uimm;
    data_t    simm;
    flags_t   flags;
    alu_out_t alu_out;
    logic     branch_taken;
    addr_t    branch_pc;
    ex_ctl_t  ctl_d;
    ex_res_t  res_d;

    // Internal state moves only on a clean cycle
    assign advance = !stall && !flush;

    ex_operand_sel opsel_i (
        .iw_clk  (iw_clk),
        .iw_rst  (iw_rst),
        .advance (advance),
        .opc     (req.opc),
        .imm     (req.imm),
        .uimm    (uimm),
        .simm    (simm)
    );

    ex_alu alu_i (
        .opc     (req.opc),
        .src_val (req.src_val),
        .tgt_val (req.tgt_val),
        .uimm    (uimm),
        .simm    (simm),
        .flags   (flags),
        .out     (alu_out)
    );

    ex_branch_unit br_i (
        .iw_clk       (iw_clk),
        .iw_rst       (iw_rst),
        .advance      (advance),
        .opc          (req.opc),
        .cc           (req.cc),
        .pc           (req.pc),
        .src_val      (req.src_val),
        .uimm         (uimm),
        .simm         (simm),
        .alu          (alu_out),
        .flags        (flags),
        .branch_taken (branch_taken),
        .branch_pc    (branch_pc)
    );

    assign ctl_d = '{pc: req.pc, instr: req.instr, opc: req.opc,
                     tgt_gp: req.tgt_gp, tgt_gp_we: req.tgt_gp_we};
    assign res_d = '{addr: alu_out.addr, result: alu_out.result,
                     branch_taken: branch_taken, branch_pc: branch_pc};

    ex_pipe_reg #(.payload_t(ex_ctl_t)) ctl_reg_i (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .stall  (stall),
        .flush  (flush),
        .d      (ctl_d),
        .q      (ctl)
    );

    ex_pipe_reg #(.payload_t(ex_res_t)) res_reg_i (
        .iw_clk (iw_clk),
        .iw_rst (iw_rst),
        .stall  (stall),
        .flush  (flush),
        .d      (res_d),
        .q      (res)
    );

endmodule

`default_nettype wire

//--- verilog/ex_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module ex_branch_unit (
    input  wire                 iw_clk,
    input  wire                 iw_rst,
    input  wire                 advance,
    input  wire ex_pkg::opc_t   opc,
    input  wire ex_pkg::cc_t    cc,
    input  wire ex_pkg::addr_t  pc,
    input  wire ex_pkg::data_t  src_val,
    input  wire ex_pkg::data_t  uimm,
    input  wire ex_pkg::data_t  simm,
    input  wire ex_pkg::alu_out_t alu,
    output ex_pkg::flags_t      flags,
    output logic                branch_taken,
    output ex_pkg::addr_t       branch_pc
);
    import ex_pkg::*;

    logic  is_branch;
    logic  cond_true;
    addr_t target;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            flags <= '0;
        end else if (advance && alu.flags_we) begin
            flags <= alu.next_flags;
        end
    end

    assign is_branch = (opc == OPC_JCCU) || (opc == OPC_BCCS) ||
                       (opc == OPC_JCCIU) || (opc == OPC_BCCIS);

    // Evaluated on flags left by the previous instruction
    always_comb begin
        case (cc)
            CC_RA:   cond_true = 1'b1;
            CC_EQ:   cond_true = flags.z;
            CC_NE:   cond_true = !flags.z;
            CC_LT:   cond_true = flags.n != flags.v;
            CC_GE:   cond_true = flags.n == flags.v;
            CC_GT:   cond_true = !flags.z && (flags.n == flags.v);
            CC_LE:   cond_true = flags.z || (flags.n != flags.v);
            CC_BT:   cond_true = flags.c;
            CC_AE:   cond_true = !flags.c;
            CC_AT:   cond_true = !flags.c && !flags.z;
            CC_BE:   cond_true = flags.c || flags.z;
            default: cond_true = 1'b0;
        endcase
    end

    always_comb begin
        case (opc)
            OPC_JCCU, OPC_BCCS: target = pc + src_val; // Signed offset wraps alike
            OPC_JCCIU:          target = uimm;
            OPC_BCCIS:          target = pc + simm;
            default:            target = '0;
        endcase
    end

    assign branch_taken = is_branch && cond_true;
    assign branch_pc    = branch_taken ? target : '0;

endmodule

`default_nettype wire

//--- alu/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  wire ex_pkg::opc_t   opc,
    input  wire ex_pkg::data_t  src_val,
    input  wire ex_pkg::data_t  tgt_val,
    input  wire ex_pkg::data_t  uimm,
    input  wire ex_pkg::data_t  simm,
    input  wire ex_pkg::flags_t flags,
    output ex_pkg::alu_out_t    out
);
    import ex_pkg::*;

    data_t                     opb;
    logic [DATA_W:0]           sum_w;
    logic [DATA_W:0]           diff_w;
    logic [SHAMT_W-1:0]        shamt;
    logic                      big_shift;
    logic                      add_ovf;
    logic                      sub_ovf;
    logic signed [DATA_W-1:0]  sar_v;
    data_t                     res;
    addr_t                     mem_addr;
    flags_t                    nf;
    logic                      nf_we;

    // Second operand per encoding group
    always_comb begin
        case (opc)
            OPC_MOVIU, OPC_ADDIU, OPC_SUBIU, OPC_ANDIU, OPC_ORIU, OPC_XORIU,
            OPC_SHLIU, OPC_SHRIU, OPC_CMPIU, OPC_STIU:
                opb = uimm;
            OPC_MOVIS, OPC_ADDIS, OPC_SUBIS, OPC_SHRIS, OPC_CMPIS, OPC_STIS:
                opb = simm;
            default:
                opb = src_val;
        endcase
    end

    assign sum_w     = {1'b0, tgt_val} + {1'b0, opb};
    assign diff_w    = {1'b0, tgt_val} - {1'b0, opb}; // Top bit is the borrow
    assign add_ovf   = (tgt_val[DATA_W-1] == opb[DATA_W-1]) &&
                       (sum_w[DATA_W-1] != tgt_val[DATA_W-1]);
    assign sub_ovf   = (tgt_val[DATA_W-1] != opb[DATA_W-1]) &&
                       (diff_w[DATA_W-1] != tgt_val[DATA_W-1]);
    assign shamt     = opb[SHAMT_W-1:0];
    assign big_shift = opb >= data_t'(DATA_W);
    assign sar_v     = $signed(tgt_val) >>> shamt;

    always_comb begin
        res      = '0;
        mem_addr = '0;
        nf       = flags;
        nf_we    = 1'b1;
        case (opc)
            OPC_MOVU, OPC_MOVIU, OPC_MOVIS: begin
                res  = opb;
                nf.z = (res == '0);
            end
            OPC_NOTU: begin
                res  = ~tgt_val;
                nf.z = (res == '0);
            end
            OPC_ANDU, OPC_ANDIU: begin
                res  = tgt_val & opb;
                nf.z = (res == '0);
            end
            OPC_ORU, OPC_ORIU: begin
                res  = tgt_val | opb;
                nf.z = (res == '0);
            end
            OPC_XORU, OPC_XORIU: begin
                res  = tgt_val ^ opb;
                nf.z = (res == '0);
            end
            OPC_ADDU, OPC_ADDIU: begin
                res  = sum_w[DATA_W-1:0];
                nf.z = (res == '0);
                nf.c = sum_w[DATA_W];
            end
            OPC_SUBU, OPC_SUBIU: begin
                res  = diff_w[DATA_W-1:0];
                nf.z = (res == '0);
                nf.c = diff_w[DATA_W];
            end
            OPC_CMPU, OPC_CMPIU: begin
                nf.z = (tgt_val == opb);
                nf.c = diff_w[DATA_W];
            end
            OPC_ADDS, OPC_ADDIS: begin
                res  = sum_w[DATA_W-1:0];
                nf.z = (res == '0);
                nf.n = res[DATA_W-1];
                nf.v = add_ovf;
            end
            OPC_SUBS, OPC_SUBIS: begin
                res  = diff_w[DATA_W-1:0];
                nf.z = (res == '0);
                nf.n = res[DATA_W-1];
                nf.v = sub_ovf;
            end
            OPC_CMPS, OPC_CMPIS: begin
                nf.z = (tgt_val == opb);
                nf.n = diff_w[DATA_W-1];
                nf.v = sub_ovf;
            end
            OPC_SHLU, OPC_SHLIU: begin
                res  = big_shift ? '0 : tgt_val << shamt;
                nf.z = (res == '0);
                nf.v = big_shift;
            end
            OPC_SHRU, OPC_SHRIU: begin
                res  = big_shift ? '0 : tgt_val >> shamt;
                nf.z = (res == '0);
                nf.v = big_shift;
            end
            OPC_SHRS, OPC_SHRIS: begin
                res  = big_shift ? '0 : data_t'(sar_v);
                nf.z = (res == '0);
                nf.n = res[DATA_W-1];
                nf.v = big_shift;
            end
            OPC_LDU: begin
                mem_addr = src_val;
                nf_we    = 1'b0;
            end
            OPC_STU, OPC_STIU, OPC_STIS: begin
                mem_addr = tgt_val;
                res      = opb; // Store data
                nf_we    = 1'b0;
            end
            OPC_LUI, OPC_JCCU, OPC_BCCS, OPC_JCCIU, OPC_BCCIS: begin
                nf_we = 1'b0;
            end
            default: begin
                nf = '0; // Unknown opcode wipes flags
            end
        endcase
    end

    assign out = '{result: res, addr: mem_addr, next_flags: nf, flags_we: nf_we};

endmodule

`default_nettype wire

//--- verilog/ex_operand_sel.sv
`timescale 1ns/1ps
`default_nettype none

module ex_operand_sel (
    input  wire               iw_clk,
    input  wire               iw_rst,
    input  wire               advance,
    input  wire ex_pkg::opc_t opc,
    input  wire ex_pkg::imm_t imm,
    output ex_pkg::data_t     uimm,
    output ex_pkg::data_t     simm
);
    import ex_pkg::*;

    imm_t upper_imm; // Top half for the IU forms

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            upper_imm <= '0;
        end else if (advance && opc == OPC_LUI) begin
            upper_imm <= imm;
        end
    end

    // Seen by the instruction after LUI
    assign uimm = {upper_imm, imm};
    assign simm = {{(DATA_W - IMM_W){imm[IMM_W-1]}}, imm};

endmodule

`default_nettype wire

//--- verilog/ex_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module ex_pipe_reg #(
    parameter type payload_t = logic
) (
    input  wire           iw_clk,
    input  wire           iw_rst,
    input  wire           stall,
    input  wire           flush,
    input  wire payload_t d,
    output payload_t      q
);

    // Flush beats stall
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            q <= '0;
        end else if (flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- common/ex_pkg.sv
`default_nettype none

package ex_pkg;

    localparam int DATA_W  = 24;
    localparam int ADDR_W  = 24;
    localparam int IMM_W   = 12;
    localparam int SHAMT_W = 5;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [IMM_W-1:0]  imm_t;
    typedef logic [7:0]        opc_t;
    typedef logic [3:0]        cc_t;
    typedef logic [3:0]        reg_idx_t;

    // Unsigned register forms
    localparam opc_t OPC_LUI   = 8'h00;
    localparam opc_t OPC_MOVU  = 8'h01;
    localparam opc_t OPC_ADDU  = 8'h02;
    localparam opc_t OPC_SUBU  = 8'h03;
    localparam opc_t OPC_NOTU  = 8'h04;
    localparam opc_t OPC_ANDU  = 8'h05;
    localparam opc_t OPC_ORU   = 8'h06;
    localparam opc_t OPC_XORU  = 8'h07;
    localparam opc_t OPC_SHLU  = 8'h08;
    localparam opc_t OPC_SHRU  = 8'h09;
    localparam opc_t OPC_CMPU  = 8'h0A;
    localparam opc_t OPC_JCCU  = 8'h0B;
    localparam opc_t OPC_LDU   = 8'h0C;
    localparam opc_t OPC_STU   = 8'h0D;
    // Signed register forms
    localparam opc_t OPC_ADDS  = 8'h10;
    localparam opc_t OPC_SUBS  = 8'h11;
    localparam opc_t OPC_SHRS  = 8'h12;
    localparam opc_t OPC_CMPS  = 8'h13;
    localparam opc_t OPC_BCCS  = 8'h14;
    // Unsigned immediate forms
    localparam opc_t OPC_MOVIU = 8'h20;
    localparam opc_t OPC_ADDIU = 8'h21;
    localparam opc_t OPC_SUBIU = 8'h22;
    localparam opc_t OPC_ANDIU = 8'h23;
    localparam opc_t OPC_ORIU  = 8'h24;
    localparam opc_t OPC_XORIU = 8'h25;
    localparam opc_t OPC_SHLIU = 8'h26;
    localparam opc_t OPC_SHRIU = 8'h27;
    localparam opc_t OPC_CMPIU = 8'h28;
    localparam opc_t OPC_JCCIU = 8'h29;
    localparam opc_t OPC_STIU  = 8'h2A;
    // Signed immediate forms
    localparam opc_t OPC_MOVIS = 8'h30;
    localparam opc_t OPC_ADDIS = 8'h31;
    localparam opc_t OPC_SUBIS = 8'h32;
    localparam opc_t OPC_SHRIS = 8'h33;
    localparam opc_t OPC_CMPIS = 8'h34;
    localparam opc_t OPC_BCCIS = 8'h35;
    localparam opc_t OPC_STIS  = 8'h36;

    localparam cc_t CC_RA = 4'h0;
    localparam cc_t CC_EQ = 4'h1;
    localparam cc_t CC_NE = 4'h2;
    localparam cc_t CC_LT = 4'h3;
    localparam cc_t CC_GT = 4'h4;
    localparam cc_t CC_GE = 4'h5;
    localparam cc_t CC_LE = 4'h6;
    localparam cc_t CC_BT = 4'h7; // Unsigned below
    localparam cc_t CC_AT = 4'h8;
    localparam cc_t CC_BE = 4'h9;
    localparam cc_t CC_AE = 4'hA;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
        logic v;
    } flags_t;

    typedef struct packed {
        addr_t    pc;
        data_t    instr;
        opc_t     opc;
        imm_t     imm;
        cc_t      cc;
        reg_idx_t tgt_gp;
        logic     tgt_gp_we;
        data_t    src_val;
        data_t    tgt_val;
    } ex_req_t;

    typedef struct packed {
        addr_t    pc;
        data_t    instr;
        opc_t     opc;
        reg_idx_t tgt_gp;
        logic     tgt_gp_we;
    } ex_ctl_t;

    typedef struct packed {
        addr_t addr;
        data_t result;
        logic  branch_taken;
        addr_t branch_pc;
    } ex_res_t;

    typedef struct packed {
        data_t  result;
        addr_t  addr;
        flags_t next_flags;
        logic   flags_we;
    } alu_out_t;

endpackage

`default_nettype wire
